// ==== Makefile ====
TOP = bpred_tb

.PHONY: all build run clean

all: run

build:
	verilator --binary --timing -sv --assert -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/bpred_pkg.sv ====
`include "bpred_settings.svh"

package bpred_pkg;

    // B-type layout, immediate bits scattered around the register fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J-type layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic                 hit;
        logic                 taken;
        logic [31:0]          target;
        logic [`GHR_BITS-1:0] pht_idx;
    } pred_t;

    // Prediction rides along from fetch so training can use it
    typedef struct packed {
        logic [31:0] pc;
        instr_u      instr;
        logic        taken;
        logic [31:0] jalr_target;
        pred_t       pred;
    } resolve_t;

    typedef struct packed {
        logic        we;
        logic [31:0] pc;
        logic [31:0] target;
        logic        is_jump;
    } btb_wr_t;

    typedef struct packed {
        logic                 we;
        logic [`GHR_BITS-1:0] idx;
        logic                 taken;
        logic                 shift;
    } pht_upd_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

// ==== hdl/bpred_settings.svh ====
`ifndef BPRED_SETTINGS_SVH
`define BPRED_SETTINGS_SVH

// Table sizes
`define BTB_ENTRIES 32
`define GHR_BITS    5

// First fetch address after reset
`define RESET_PC    32'h0000_1000

// RV32I control-flow opcodes
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111

`endif

// ==== hdl/bpred_top.sv ====
`include "bpred_settings.svh"

module bpred_top (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 resolve_valid_i,
    input  bpred_pkg::resolve_t  resolve_i,
    input  logic                 fetch_stall_i,
    output logic [31:0]          fetch_pc_o,
    output bpred_pkg::pred_t     pred_o,
    output bpred_pkg::redirect_t redirect_o
);

    import bpred_pkg::*;

    btb_wr_t              btb_wr;
    pht_upd_t             pht_upd;
    logic                 btb_hit;
    logic                 btb_is_jump;
    logic [31:0]          btb_target;
    logic                 counter_taken;
    logic [`GHR_BITS-1:0] pht_idx;

    branch_resolve u_resolve (
        .clk             (clk),
        .reset_i         (reset_i),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .btb_wr_o        (btb_wr),
        .pht_upd_o       (pht_upd),
        .redirect_o      (redirect_o)
    );

    btb u_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .lookup_pc_i (fetch_pc_o),
        .hit_o       (btb_hit),
        .is_jump_o   (btb_is_jump),
        .target_o    (btb_target),
        .wr_i        (btb_wr)
    );

    gshare u_gshare (
        .clk             (clk),
        .reset_i         (reset_i),
        .lookup_pc_i     (fetch_pc_o),
        .pht_idx_o       (pht_idx),
        .counter_taken_o (counter_taken),
        .upd_i           (pht_upd)
    );

    fetch_pc_gen u_pc_gen (
        .clk             (clk),
        .reset_i         (reset_i),
        .fetch_stall_i   (fetch_stall_i),
        .redirect_i      (redirect_o),
        .btb_hit_i       (btb_hit),
        .btb_is_jump_i   (btb_is_jump),
        .btb_target_i    (btb_target),
        .counter_taken_i (counter_taken),
        .pht_idx_i       (pht_idx),
        .fetch_pc_o      (fetch_pc_o),
        .pred_o          (pred_o)
    );

endmodule

// ==== hdl/branch_resolve.sv ====
`include "bpred_settings.svh"

module branch_resolve (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 resolve_valid_i,
    input  bpred_pkg::resolve_t  resolve_i,
    output bpred_pkg::btb_wr_t   btb_wr_o,
    output bpred_pkg::pht_upd_t  pht_upd_o,
    output bpred_pkg::redirect_t redirect_o
);

    import bpred_pkg::*;

    logic [6:0]  opcode;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic        is_jump;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic [31:0] true_target;
    logic        actual_taken;
    logic [31:0] actual_next_pc;
    logic        mispredict;

    // Opcode sits in the same bits for both formats
    assign opcode    = resolve_i.instr.b_fmt.opcode;
    assign is_branch = (opcode == `OP_BRANCH);
    assign is_jal    = (opcode == `OP_JAL);
    assign is_jalr   = (opcode == `OP_JALR);
    assign is_jump   = is_jal | is_jalr;

    assign b_imm = {{19{resolve_i.instr.b_fmt.imm12}}, resolve_i.instr.b_fmt.imm12,
                    resolve_i.instr.b_fmt.imm11, resolve_i.instr.b_fmt.imm10_5,
                    resolve_i.instr.b_fmt.imm4_1, 1'b0};
    assign j_imm = {{11{resolve_i.instr.j_fmt.imm20}}, resolve_i.instr.j_fmt.imm20,
                    resolve_i.instr.j_fmt.imm19_12, resolve_i.instr.j_fmt.imm11,
                    resolve_i.instr.j_fmt.imm10_1, 1'b0};

    always_comb begin
        if (is_jalr) begin
            true_target = resolve_i.jalr_target;
        end else if (is_jal) begin
            true_target = resolve_i.pc + j_imm;
        end else begin
            true_target = resolve_i.pc + b_imm;
        end
    end

    // Jumps are always taken, non-control instructions never
    assign actual_taken   = is_jump | (is_branch & resolve_i.taken);
    assign actual_next_pc = actual_taken ? true_target : resolve_i.pc + 32'd4;

    assign mispredict = (resolve_i.pred.taken != actual_taken) ||
                        (actual_taken && (resolve_i.pred.target != true_target));

    assign redirect_o.valid = resolve_valid_i & mispredict;
    assign redirect_o.pc    = actual_next_pc;

    assign btb_wr_o.we      = resolve_valid_i & actual_taken;
    assign btb_wr_o.pc      = resolve_i.pc;
    assign btb_wr_o.target  = true_target;
    assign btb_wr_o.is_jump = is_jump;

    // Counter uses the index the fetch saw, not a recomputed one
    assign pht_upd_o.we    = resolve_valid_i & is_branch;
    assign pht_upd_o.idx   = resolve_i.pred.pht_idx;
    assign pht_upd_o.taken = actual_taken;
    assign pht_upd_o.shift = resolve_valid_i & (is_branch | is_jump);

    assert property (@(posedge clk) reset_i |-> !redirect_o.valid)
        else $error("redirect raised during reset");

endmodule

// ==== hdl/btb.sv ====
`include "bpred_settings.svh"

module btb (
    input  logic               clk,
    input  logic               reset_i,
    input  logic [31:0]        lookup_pc_i,
    output logic               hit_o,
    output logic               is_jump_o,
    output logic [31:0]        target_o,
    input  bpred_pkg::btb_wr_t wr_i
);

    import bpred_pkg::*;

    localparam int IDX_BITS = $clog2(`BTB_ENTRIES);
    localparam int TAG_BITS = 32 - IDX_BITS - 2;

    logic [`BTB_ENTRIES-1:0] valid_q;
    logic [TAG_BITS-1:0]     tag_q    [`BTB_ENTRIES];
    logic [31:0]             target_q [`BTB_ENTRIES];
    logic                    jump_q   [`BTB_ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0] rd_tag;
    logic [IDX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0] wr_tag;

    // Word aligned PCs, so bits 1:0 are skipped
    assign rd_idx = lookup_pc_i[IDX_BITS+1:2];
    assign rd_tag = lookup_pc_i[31:IDX_BITS+2];
    assign wr_idx = wr_i.pc[IDX_BITS+1:2];
    assign wr_tag = wr_i.pc[31:IDX_BITS+2];

    assign hit_o     = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign is_jump_o = hit_o & jump_q[rd_idx];
    assign target_o  = hit_o ? target_q[rd_idx] : 32'd0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_i.we) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_i.target;
            jump_q[wr_idx]   <= wr_i.is_jump;
        end
    end

endmodule

// ==== hdl/fetch_pc_gen.sv ====
`include "bpred_settings.svh"

module fetch_pc_gen (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 fetch_stall_i,
    input  bpred_pkg::redirect_t redirect_i,
    input  logic                 btb_hit_i,
    input  logic                 btb_is_jump_i,
    input  logic [31:0]          btb_target_i,
    input  logic                 counter_taken_i,
    input  logic [`GHR_BITS-1:0] pht_idx_i,
    output logic [31:0]          fetch_pc_o,
    output bpred_pkg::pred_t     pred_o
);

    import bpred_pkg::*;

    logic [31:0] pc_q;

    // Jumps always taken on a hit, branches follow the counter
    assign pred_o.hit     = btb_hit_i;
    assign pred_o.taken   = btb_hit_i & (btb_is_jump_i | counter_taken_i);
    assign pred_o.target  = btb_target_i;
    assign pred_o.pht_idx = pht_idx_i;

    assign fetch_pc_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.pc;  // wins over a stall
        end else if (!fetch_stall_i) begin
            pc_q <= pred_o.taken ? pred_o.target : pc_q + 32'd4;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i) fetch_pc_o[1:0] == 2'b00)
        else $error("fetch PC not word aligned");

endmodule

// ==== hdl/gshare.sv ====
`include "bpred_settings.svh"

module gshare (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic [31:0]          lookup_pc_i,
    output logic [`GHR_BITS-1:0] pht_idx_o,
    output logic                 counter_taken_o,
    input  bpred_pkg::pht_upd_t  upd_i
);

    import bpred_pkg::*;

    localparam int PHT_ENTRIES = 1 << `GHR_BITS;

    logic [`GHR_BITS-1:0] ghr_q;
    logic [1:0]           pht_q [PHT_ENTRIES];

    assign pht_idx_o       = ghr_q ^ lookup_pc_i[`GHR_BITS+1:2];
    assign counter_taken_o = pht_q[pht_idx_o][1];

    // History holds real outcomes only
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (upd_i.shift) begin
            ghr_q <= {ghr_q[`GHR_BITS-2:0], upd_i.taken};
        end
    end

    // 2-bit saturating counters, start weakly not taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (upd_i.we) begin
            if (upd_i.taken) begin
                if (pht_q[upd_i.idx] != 2'b11) begin
                    pht_q[upd_i.idx] <= pht_q[upd_i.idx] + 2'b01;
                end
            end else begin
                if (pht_q[upd_i.idx] != 2'b00) begin
                    pht_q[upd_i.idx] <= pht_q[upd_i.idx] - 2'b01;
                end
            end
        end
    end

endmodule

// ==== tests/bpred_checker.sv ====
`include "bpred_settings.svh"

module bpred_checker (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 resolve_valid_i,
    input  bpred_pkg::resolve_t  resolve_i,
    input  logic                 fetch_stall_i,
    input  logic [31:0]          fetch_pc_i,
    input  bpred_pkg::pred_t     pred_i,
    input  bpred_pkg::redirect_t redirect_i
);

    import bpred_pkg::*;

    localparam int IDX_BITS    = $clog2(`BTB_ENTRIES);
    localparam int TAG_BITS    = 32 - IDX_BITS - 2;
    localparam int PHT_ENTRIES = 1 << `GHR_BITS;

    int error_count = 0;

    // Reference state
    logic [31:0]          m_pc;
    logic                 m_valid  [`BTB_ENTRIES];
    logic [TAG_BITS-1:0]  m_tag    [`BTB_ENTRIES];
    logic [31:0]          m_target [`BTB_ENTRIES];
    logic                 m_jump   [`BTB_ENTRIES];
    logic [1:0]           m_pht    [PHT_ENTRIES];
    logic [`GHR_BITS-1:0] m_ghr;

    function automatic logic [31:0] imm_b(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    always @(posedge clk) begin : check_cycle
        logic [IDX_BITS-1:0]  idx;
        logic [IDX_BITS-1:0]  widx;
        logic [`GHR_BITS-1:0] pidx;
        logic                 e_hit;
        logic                 e_taken;
        logic [31:0]          e_target;
        logic [31:0]          w;
        logic [6:0]           op;
        logic                 is_br;
        logic                 is_jump;
        logic                 act;
        logic                 mis;
        logic [31:0]          tgt;
        logic [31:0]          nxt;
        logic [31:0]          next_pc;

        if (reset_i) begin
            m_pc  = `RESET_PC;
            m_ghr = '0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                m_valid[i] = 1'b0;
            end
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                m_pht[i] = 2'b01;
            end
        end else begin
            // Prediction for the current fetch PC
            idx      = m_pc[IDX_BITS+1:2];
            e_hit    = m_valid[idx] && (m_tag[idx] == m_pc[31:IDX_BITS+2]);
            pidx     = m_ghr ^ m_pc[`GHR_BITS+1:2];
            e_taken  = e_hit && (m_jump[idx] || m_pht[pidx][1]);
            e_target = e_hit ? m_target[idx] : 32'd0;

            compare("fetch_pc", fetch_pc_i, m_pc);
            compare("pred.hit", 32'(pred_i.hit), 32'(e_hit));
            compare("pred.taken", 32'(pred_i.taken), 32'(e_taken));
            compare("pred.target", pred_i.target, e_target);
            compare("pred.pht_idx", 32'(pred_i.pht_idx), 32'(pidx));

            // Resolved instruction
            w       = resolve_i.instr;
            op      = w[6:0];
            is_br   = (op == `OP_BRANCH);
            is_jump = (op == `OP_JAL) || (op == `OP_JALR);
            act     = is_jump || (is_br && resolve_i.taken);
            if (op == `OP_JALR) begin
                tgt = resolve_i.jalr_target;
            end else if (op == `OP_JAL) begin
                tgt = resolve_i.pc + imm_j(w);
            end else begin
                tgt = resolve_i.pc + imm_b(w);
            end
            nxt = act ? tgt : resolve_i.pc + 32'd4;
            mis = resolve_valid_i &&
                  ((resolve_i.pred.taken != act) || (act && resolve_i.pred.target != tgt));

            compare("redirect.valid", 32'(redirect_i.valid), 32'(mis));
            if (mis) begin
                compare("redirect.pc", redirect_i.pc, nxt);
            end

            if (mis) begin
                next_pc = nxt;
            end else if (fetch_stall_i) begin
                next_pc = m_pc;
            end else begin
                next_pc = e_taken ? e_target : m_pc + 32'd4;
            end

            if (resolve_valid_i) begin
                widx = resolve_i.pc[IDX_BITS+1:2];
                if (act) begin
                    m_valid[widx]  = 1'b1;
                    m_tag[widx]    = resolve_i.pc[31:IDX_BITS+2];
                    m_target[widx] = tgt;
                    m_jump[widx]   = is_jump;
                end
                if (is_br) begin
                    pidx = resolve_i.pred.pht_idx;
                    if (act && m_pht[pidx] != 2'b11) begin
                        m_pht[pidx] = m_pht[pidx] + 2'b01;
                    end else if (!act && m_pht[pidx] != 2'b00) begin
                        m_pht[pidx] = m_pht[pidx] - 2'b01;
                    end
                end
                if (is_br || is_jump) begin
                    m_ghr = {m_ghr[`GHR_BITS-2:0], act};
                end
            end
            m_pc = next_pc;
        end
    end

endmodule

// ==== tests/bpred_tb.sv ====
`include "bpred_settings.svh"

module bpred_tb;

    import bpred_pkg::*;

    localparam int NUM_ROWS    = 29;
    localparam int CYCLE_LIMIT = NUM_ROWS + 20;

    localparam logic [31:0] JAL_P40   = 32'h0400_006F;
    localparam logic [31:0] JALR_W    = 32'h0000_0067;
    localparam logic [31:0] BR_M40    = 32'hFC00_00E3;

    typedef struct packed {
        logic        stall;
        logic        rv;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        taken;
        logic [31:0] jalr;
        logic [31:0] exp_pc;
    } row_t;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       resolve_valid_i;
    resolve_t   resolve_i;
    logic       fetch_stall_i;
    logic [31:0] fetch_pc_o;
    pred_t      pred_o;
    redirect_t  redirect_o;

    row_t  table_q[$];
    pred_t pred_seen[logic [31:0]];
    int    pc_errors = 0;
    int    cycle_count = 0;

    always #20 clk = ~clk;

    bpred_top dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .fetch_stall_i   (fetch_stall_i),
        .fetch_pc_o      (fetch_pc_o),
        .pred_o          (pred_o),
        .redirect_o      (redirect_o)
    );

    bpred_checker chk (
        .clk             (clk),
        .reset_i         (reset_i),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .fetch_stall_i   (fetch_stall_i),
        .fetch_pc_i      (fetch_pc_o),
        .pred_i          (pred_o),
        .redirect_i      (redirect_o)
    );

    task automatic add_row(input logic stall, input logic rv, input logic [31:0] pc,
                           input logic [31:0] instr, input logic taken,
                           input logic [31:0] jalr, input logic [31:0] exp_pc);
        table_q.push_back({stall, rv, pc, instr, taken, jalr, exp_pc});
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        row_t r;

        reset_i         = 1'b1;
        resolve_valid_i = 1'b0;
        resolve_i       = '0;
        fetch_stall_i   = 1'b0;

        // Sequential fetch, then JAL learned and followed
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h1000);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h1004);
        add_row(0, 1, 32'h1004, JAL_P40, 1, 32'h0,    32'h1008);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h1044);
        add_row(0, 1, 32'h2000, JALR_W,  1, 32'h1004, 32'h1048);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h1004);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h1044);
        // Two taken resolutions of a backward branch
        add_row(0, 1, 32'h1048, BR_M40,  1, 32'h0,    32'h1048);
        add_row(0, 1, 32'h1048, BR_M40,  1, 32'h0,    32'h1008);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h1008);
        // Stall, then a JALR with a new target redirects through it
        add_row(1, 0, 32'h0,    32'h0,   0, 32'h0,    32'h100c);
        add_row(1, 1, 32'h1004, JALR_W,  1, 32'h3000, 32'h100c);
        // 0x3000 shares an index with 0x2000
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h3000);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h3004);
        // Counter walks down and saturates
        add_row(0, 1, 32'h1048, BR_M40,  0, 32'h0,    32'h3008);
        add_row(0, 1, 32'h1048, BR_M40,  0, 32'h0,    32'h300c);
        add_row(0, 1, 32'h1048, BR_M40,  0, 32'h0,    32'h3010);
        add_row(0, 1, 32'h1048, BR_M40,  0, 32'h0,    32'h3014);
        // Correctly predicted JAL
        add_row(0, 1, 32'h1004, JAL_P40, 1, 32'h0,    32'h3018);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h301c);
        // Taken jumps fill the history so the branch index repeats
        add_row(0, 1, 32'h2000, JALR_W,  1, 32'h1048, 32'h3020);
        add_row(0, 1, 32'h2000, JALR_W,  1, 32'h1048, 32'h1048);
        add_row(0, 1, 32'h2000, JALR_W,  1, 32'h1048, 32'h1048);
        add_row(0, 1, 32'h2000, JALR_W,  1, 32'h1048, 32'h1048);
        // Two taken resolutions at that index, then the branch predicts taken
        add_row(0, 1, 32'h1048, BR_M40,  1, 32'h0,    32'h1048);
        add_row(0, 1, 32'h1048, BR_M40,  1, 32'h0,    32'h1008);
        add_row(0, 1, 32'h2000, JALR_W,  1, 32'h1048, 32'h1008);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h1048);
        add_row(0, 0, 32'h0,    32'h0,   0, 32'h0,    32'h1008);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        foreach (table_q[i]) begin
            r = table_q[i];
            pred_seen[fetch_pc_o] = pred_o;
            if (fetch_pc_o !== r.exp_pc) begin
                $display("MISMATCH t=%0t row %0d fetch_pc %h, expected %h",
                         $time, i, fetch_pc_o, r.exp_pc);
                pc_errors++;
            end
            fetch_stall_i         = r.stall;
            resolve_valid_i       = r.rv;
            resolve_i.pc          = r.pc;
            resolve_i.instr       = r.instr;
            resolve_i.taken       = r.taken;
            resolve_i.jalr_target = r.jalr;
            // Pipeline carries the prediction made when this PC was fetched
            resolve_i.pred        = pred_seen.exists(r.pc) ? pred_seen[r.pc] : '0;
            @(negedge clk);
        end

        resolve_valid_i = 1'b0;
        fetch_stall_i   = 1'b0;
        repeat (2) @(negedge clk);

        $display("Errors: checker %0d, fetch sequence %0d", chk.error_count, pc_errors);
        if (chk.error_count == 0 && pc_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/bpred_pkg.sv
hdl/branch_resolve.sv
hdl/btb.sv
hdl/gshare.sv
hdl/fetch_pc_gen.sv
hdl/bpred_top.sv
tests/bpred_checker.sv
tests/bpred_tb.sv
